/* common/audioPkg.sv */
package audioPkg;

	// audio stream and band split
	localparam int numBands = 7;
	localparam int sampleWidth = 16;
	localparam int stateWidth = 18;

	// envelope follower
	localparam int envWidth = 16;
	localparam int envShift = 3;

	// lowest bar threshold is 2**levelBase, one octave per step
	localparam int levelBase = 8;

	// mix of all bands back into one stream
	localparam int mixShift = 3;
	localparam int mixSumWidth = stateWidth + $clog2(numBands);

	// bar level 0..7
	typedef logic [2:0] bandLevelT;

	// one enable bit per band
	typedef logic [numBands-1:0] bandMaskT;

	// bar levels of all bands
	typedef bandLevelT [numBands-1:0] bandVecT;

	// filter state and band value
	typedef logic signed [stateWidth-1:0] stateT;

	// band values of all bands
	typedef stateT [numBands-1:0] bandArrT;

endpackage

/* common/screenPkg.sv */
package screenPkg;

	// raster coordinate widths for 640x480
	localparam int xWidth = 10;
	localparam int yWidth = 9;

	// block grid, one column per band
	localparam int gridX0 = 10;
	localparam int gridY0 = 10;
	localparam int gridRows = 7;
	localparam int colPitch = 90;
	localparam int colWidth = 80;
	localparam int rowPitch = 68;
	localparam int rowHeight = 60;

	// sprite box and its motion
	localparam int spriteSize = 32;
	localparam int sprOffWidth = $clog2(spriteSize);
	localparam int checkerBit = 2;
	localparam int bobStep = 4;

	typedef logic [2:0] gridIdxT;

	typedef struct packed {
		logic [xWidth-1:0] x;
		logic [yWidth-1:0] y;
	} pixelT;

	// col of 7 marks a pixel outside every column
	typedef struct packed {
		gridIdxT col;
		gridIdxT row;
		logic inBlock;
		logic inSprite;
		logic [sprOffWidth-1:0] sprDx;
		logic [sprOffWidth-1:0] sprDy;
	} tileT;

	typedef struct packed {
		logic blockLit;
		logic spriteHit;
		gridIdxT col;
	} layerT;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgbT;

	// low bands warm, high bands cool
	localparam rgbT palette [0:audioPkg::numBands-1] = '{
		24'hFF2020, 24'hFF8C00, 24'hFFE000, 24'h30D040,
		24'h00C8E0, 24'h3060FF, 24'hB040FF
	};
	localparam rgbT spriteColor = 24'hFFFFF0;
	localparam rgbT bgColor = 24'h101018;

	// Wishbone classic
	localparam int wbAdrWidth = 2;
	localparam int wbDataWidth = 32;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [wbAdrWidth-1:0] adr;
		logic [wbDataWidth-1:0] dat;
	} wbReqT;

	typedef struct packed {
		logic ack;
		logic [wbDataWidth-1:0] dat;
	} wbRspT;

	// register map
	localparam logic [wbAdrWidth-1:0] regBandEn = 2'd0;
	localparam logic [wbAdrWidth-1:0] regSprCtrl = 2'd1;
	localparam logic [wbAdrWidth-1:0] regSprX = 2'd2;
	localparam logic [wbAdrWidth-1:0] regSprY = 2'd3;

endpackage

/* audio/bandFilterBank.sv */
`timescale 1ns/100ps

module bandFilterBank
	import audioPkg::*;
(
	input logic clk,
	input logic rst,
	input logic sampleValid,
	input logic signed [sampleWidth-1:0] sample,
	input bandMaskT bandEn,
	output logic bandValid,
	output bandArrT band,
	output logic audValid,
	output logic signed [sampleWidth-1:0] audOut
);

	stateT lp [numBands];
	stateT lpNext [numBands];
	bandArrT bandNext;
	logic signed [mixSumWidth-1:0] mixSum;
	logic signed [mixSumWidth-1:0] mixShifted;
	logic signed [sampleWidth-1:0] mixSat;

	// each section sees the freshly updated output of the one before it
	always_comb begin
		stateT prev;
		stateT diff;
		prev = {{(stateWidth - sampleWidth){sample[sampleWidth-1]}}, sample};
		for (int i = 0; i < numBands; i++) begin
			diff = prev - lp[i];
			lpNext[i] = lp[i] + (diff >>> (i + 1));
			bandNext[i] = bandEn[i] ? prev - lpNext[i] : '0;
			prev = lpNext[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bandValid <= 1'b0;
			for (int i = 0; i < numBands; i++) begin
				lp[i] <= '0;
			end
		end else begin
			bandValid <= sampleValid;
			if (sampleValid) begin
				for (int i = 0; i < numBands; i++) begin
					lp[i] <= lpNext[i];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sampleValid) begin
			band <= bandNext;
		end
	end

	// sum of the gated bands, scaled down
	always_comb begin
		mixSum = '0;
		for (int i = 0; i < numBands; i++) begin
			mixSum = mixSum + {{(mixSumWidth - stateWidth){band[i][stateWidth-1]}}, band[i]};
		end
		mixShifted = mixSum >>> mixShift;
	end

	// clip to 16 bits when the upper bits are not a pure sign extension
	always_comb begin
		if (mixShifted[mixSumWidth-1:sampleWidth-1] == '0 ||
				mixShifted[mixSumWidth-1:sampleWidth-1] == '1) begin
			mixSat = mixShifted[sampleWidth-1:0];
		end else begin
			mixSat = {mixShifted[mixSumWidth-1], {(sampleWidth - 1){~mixShifted[mixSumWidth-1]}}};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			audValid <= 1'b0;
		end else begin
			audValid <= bandValid;
		end
	end

	always_ff @(posedge clk) begin
		if (bandValid) begin
			audOut <= mixSat;
		end
	end

endmodule

/* audio/bandMeter.sv */
`timescale 1ns/100ps

module bandMeter
	import audioPkg::*;
(
	input logic clk,
	input logic rst,
	input logic bandValid,
	input bandArrT band,
	output bandVecT levels
);

	logic [envWidth-1:0] env [numBands];
	logic [envWidth-1:0] envNext [numBands];
	bandVecT levelNext;

	always_comb begin
		logic [stateWidth-1:0] mag;
		logic [envWidth-1:0] clipped;
		logic signed [envWidth:0] step;
		logic signed [envWidth:0] stepSh;
		logic signed [envWidth:0] envSum;
		for (int i = 0; i < numBands; i++) begin
			// magnitude as unsigned so the most negative band still fits
			mag = band[i][stateWidth-1] ? -band[i] : band[i];
			clipped = (|mag[stateWidth-1:envWidth]) ? '1 : mag[envWidth-1:0];
			step = $signed({1'b0, clipped}) - $signed({1'b0, env[i]});
			stepSh = step >>> envShift;
			envSum = $signed({1'b0, env[i]}) + stepSh;
			envNext[i] = envSum[envWidth-1:0];

			// count the octave thresholds reached
			levelNext[i] = '0;
			for (int r = 0; r < numBands; r++) begin
				if (env[i] >= (envWidth'(1) << (levelBase + r))) begin
					levelNext[i] = levelNext[i] + 3'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			levels <= '0;
			for (int i = 0; i < numBands; i++) begin
				env[i] <= '0;
			end
		end else begin
			levels <= levelNext;
			if (bandValid) begin
				for (int i = 0; i < numBands; i++) begin
					env[i] <= envNext[i];
				end
			end
		end
	end

endmodule

/* src/ctrlRegs.sv */
`timescale 1ns/100ps

module ctrlRegs
	import audioPkg::*;
	import screenPkg::*;
(
	input logic clk,
	input logic rst,
	input wbReqT wbIn,
	output wbRspT wbOut,
	output bandMaskT bandEn,
	output logic sprEn,
	output logic [xWidth-1:0] sprX,
	output logic [yWidth-1:0] sprY
);

	logic ackQ;
	logic [wbDataWidth-1:0] datQ;
	logic access;

	// an ack in flight blocks the same access from being taken twice
	assign access = wbIn.cyc && wbIn.stb && !ackQ;

	always_ff @(posedge clk) begin
		if (rst) begin
			ackQ <= 1'b0;
			bandEn <= '1;
			sprEn <= 1'b0;
			sprX <= '0;
			sprY <= '0;
		end else begin
			ackQ <= access;
			if (access && wbIn.we) begin
				case (wbIn.adr)
					regBandEn: bandEn <= wbIn.dat[numBands-1:0];
					regSprCtrl: sprEn <= wbIn.dat[0];
					regSprX: sprX <= wbIn.dat[xWidth-1:0];
					regSprY: sprY <= wbIn.dat[yWidth-1:0];
					default: ;
				endcase
			end
		end
	end

	// read data, zero extended
	always_ff @(posedge clk) begin
		if (access) begin
			case (wbIn.adr)
				regBandEn: datQ <= wbDataWidth'(bandEn);
				regSprCtrl: datQ <= wbDataWidth'(sprEn);
				regSprX: datQ <= wbDataWidth'(sprX);
				default: datQ <= wbDataWidth'(sprY);
			endcase
		end
	end

	assign wbOut.ack = ackQ;
	assign wbOut.dat = datQ;

endmodule

/* screen/tileLocate.sv */
`timescale 1ns/100ps

module tileLocate
	import audioPkg::*;
	import screenPkg::*;
(
	input logic clk,
	input logic rst,
	input logic pixValid,
	input pixelT pix,
	input bandVecT levels,
	input logic [xWidth-1:0] sprX,
	input logic [yWidth-1:0] sprY,
	output logic tileValid,
	output tileT tile
);

	tileT tileNext;
	logic [yWidth-1:0] sprOy;
	logic [xWidth-1:0] sprDxFull;
	logic [yWidth-1:0] sprDyFull;

	// sprite bobs upward with band 0, wrapping at the top
	assign sprOy = sprY - yWidth'(bobStep * levels[0]);
	assign sprDxFull = pix.x - sprX;
	assign sprDyFull = pix.y - sprOy;

	always_comb begin
		int colStart;
		int rowStart;
		logic inColX;
		logic inRowY;
		tileNext.col = 3'd7;
		tileNext.row = 3'd7;
		inColX = 1'b0;
		inRowY = 1'b0;
		for (int i = 0; i < numBands; i++) begin
			colStart = gridX0 + i * colPitch;
			if (int'(pix.x) >= colStart && int'(pix.x) < colStart + colPitch) begin
				tileNext.col = gridIdxT'(i);
				inColX = int'(pix.x) < colStart + colWidth;
			end
		end
		for (int j = 0; j < gridRows; j++) begin
			rowStart = gridY0 + j * rowPitch;
			if (int'(pix.y) >= rowStart && int'(pix.y) < rowStart + rowPitch) begin
				tileNext.row = gridIdxT'(j);
				inRowY = int'(pix.y) < rowStart + rowHeight;
			end
		end
		tileNext.inBlock = inColX && inRowY;
		tileNext.inSprite = sprDxFull < spriteSize && sprDyFull < spriteSize;
		tileNext.sprDx = sprDxFull[sprOffWidth-1:0];
		tileNext.sprDy = sprDyFull[sprOffWidth-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tileValid <= 1'b0;
		end else begin
			tileValid <= pixValid;
		end
	end

	always_ff @(posedge clk) begin
		tile <= tileNext;
	end

endmodule

/* screen/layerEval.sv */
`timescale 1ns/100ps

module layerEval
	import audioPkg::*;
	import screenPkg::*;
(
	input logic clk,
	input logic rst,
	input logic tileValid,
	input tileT tile,
	input bandVecT levels,
	input logic sprEn,
	output logic layerValid,
	output layerT layer
);

	layerT layerNext;
	logic checkerOn;

	// alternate 4x4 cells of the sprite are see-through
	assign checkerOn = !(tile.sprDx[checkerBit] ^ tile.sprDy[checkerBit]);

	always_comb begin
		layerNext.col = tile.col;
		layerNext.blockLit = 1'b0;
		// bar grows from the bottom row up
		if (tile.inBlock && tile.col < numBands) begin
			layerNext.blockLit = (4'(levels[tile.col]) + 4'(tile.row)) > 4'(gridRows - 1);
		end
		layerNext.spriteHit = sprEn && tile.inSprite && checkerOn;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			layerValid <= 1'b0;
		end else begin
			layerValid <= tileValid;
		end
	end

	always_ff @(posedge clk) begin
		layer <= layerNext;
	end

endmodule

/* screen/compositor.sv */
`timescale 1ns/100ps

module compositor
	import screenPkg::*;
(
	input logic clk,
	input logic rst,
	input logic layerValid,
	input layerT layer,
	output logic rgbValid,
	output rgbT rgb
);

	rgbT rgbNext;

	// sprite on top, then the lit block, then background
	always_comb begin
		if (layer.spriteHit) begin
			rgbNext = spriteColor;
		end else if (layer.blockLit) begin
			rgbNext = palette[layer.col];
		end else begin
			rgbNext = bgColor;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rgbValid <= 1'b0;
		end else begin
			rgbValid <= layerValid;
		end
	end

	always_ff @(posedge clk) begin
		rgb <= rgbNext;
	end

endmodule

/* src/visualizerTop.sv */
`timescale 1ns/100ps

module visualizerTop
	import audioPkg::*;
	import screenPkg::*;
(
	input logic clk,
	input logic rst,
	input logic sampleValid,
	input logic signed [sampleWidth-1:0] sample,
	input wbReqT wbIn,
	output wbRspT wbOut,
	input logic pixValid,
	input pixelT pix,
	output logic rgbValid,
	output rgbT rgb,
	output logic audValid,
	output logic signed [sampleWidth-1:0] audOut
);

	bandMaskT bandEn;
	logic sprEn;
	logic [xWidth-1:0] sprX;
	logic [yWidth-1:0] sprY;
	logic bandValid;
	bandArrT band;
	bandVecT levels;
	logic tileValid;
	tileT tile;
	logic layerValid;
	layerT layer;

	ctrlRegs ctrlRegs_inst (
		.clk(clk), .rst(rst), .wbIn(wbIn), .wbOut(wbOut),
		.bandEn(bandEn), .sprEn(sprEn), .sprX(sprX), .sprY(sprY)
	);

	// audio side
	bandFilterBank bandFilterBank_inst (
		.clk(clk), .rst(rst), .sampleValid(sampleValid), .sample(sample),
		.bandEn(bandEn), .bandValid(bandValid), .band(band),
		.audValid(audValid), .audOut(audOut)
	);

	bandMeter bandMeter_inst (
		.clk(clk), .rst(rst), .bandValid(bandValid), .band(band), .levels(levels)
	);

	// pixel pipeline, three stages
	tileLocate tileLocate_inst (
		.clk(clk), .rst(rst), .pixValid(pixValid), .pix(pix), .levels(levels),
		.sprX(sprX), .sprY(sprY), .tileValid(tileValid), .tile(tile)
	);

	layerEval layerEval_inst (
		.clk(clk), .rst(rst), .tileValid(tileValid), .tile(tile), .levels(levels),
		.sprEn(sprEn), .layerValid(layerValid), .layer(layer)
	);

	compositor compositor_inst (
		.clk(clk), .rst(rst), .layerValid(layerValid), .layer(layer),
		.rgbValid(rgbValid), .rgb(rgb)
	);

endmodule

/* verif/visualizerModel.svh */
`ifndef VISUALIZER_MODEL_SVH
`define VISUALIZER_MODEL_SVH

// model state: filter sections, envelopes and register copies
int lpM [numBands];
int envM [numBands];
bandMaskT bandEnM;
logic sprEnM;
int sprXM;
int sprYM;

function automatic void resetModel();
	for (int i = 0; i < numBands; i++) begin
		lpM[i] = 0;
		envM[i] = 0;
	end
	bandEnM = '1;
	sprEnM = 1'b0;
	sprXM = 0;
	sprYM = 0;
endfunction

function automatic void applyWrite(input logic [wbAdrWidth-1:0] adr,
		input logic [wbDataWidth-1:0] dat);
	case (adr)
		regBandEn: bandEnM = dat[numBands-1:0];
		regSprCtrl: sprEnM = dat[0];
		regSprX: sprXM = int'(dat[xWidth-1:0]);
		default: sprYM = int'(dat[yWidth-1:0]);
	endcase
endfunction

function automatic logic [wbDataWidth-1:0] regValue(input logic [wbAdrWidth-1:0] adr);
	case (adr)
		regBandEn: return wbDataWidth'(bandEnM);
		regSprCtrl: return wbDataWidth'(sprEnM);
		regSprX: return wbDataWidth'(sprXM);
		default: return wbDataWidth'(sprYM);
	endcase
endfunction

// one sample through the filter chain, envelopes and mix
function automatic logic signed [sampleWidth-1:0] stepAudio(input int s);
	int prev;
	int bandV;
	int mag;
	int sum;
	prev = s;
	sum = 0;
	for (int i = 0; i < numBands; i++) begin
		lpM[i] = lpM[i] + ((prev - lpM[i]) >>> (i + 1));
		bandV = bandEnM[i] ? prev - lpM[i] : 0;
		prev = lpM[i];
		mag = (bandV < 0) ? -bandV : bandV;
		if (mag > 65535) begin
			mag = 65535;
		end
		envM[i] = envM[i] + ((mag - envM[i]) >>> envShift);
		sum = sum + bandV;
	end
	sum = sum >>> mixShift;
	if (sum > 32767) begin
		sum = 32767;
	end else if (sum < -32768) begin
		sum = -32768;
	end
	return sampleWidth'(sum);
endfunction

// thresholds reached by one envelope
function automatic int levelOf(input int b);
	int lvl;
	lvl = 0;
	for (int r = 0; r < numBands; r++) begin
		if (envM[b] >= (1 << (levelBase + r))) begin
			lvl++;
		end
	end
	return lvl;
endfunction

function automatic int spriteOriginY();
	return (sprYM - bobStep * levelOf(0)) & ((1 << yWidth) - 1);
endfunction

function automatic rgbT pixelColor(input int x, input int y);
	int col;
	int row;
	int dx;
	int dy;
	logic inBlock;
	logic lit;
	col = (x >= gridX0) ? (x - gridX0) / colPitch : numBands;
	row = (y >= gridY0) ? (y - gridY0) / rowPitch : gridRows;
	inBlock = col < numBands && row < gridRows && (x - gridX0) % colPitch < colWidth &&
		(y - gridY0) % rowPitch < rowHeight;
	lit = inBlock && levelOf(col) > (gridRows - 1) - row;
	dx = (x - sprXM) & ((1 << xWidth) - 1);
	dy = (y - spriteOriginY()) & ((1 << yWidth) - 1);
	if (sprEnM && dx < spriteSize && dy < spriteSize && (((dx ^ dy) >> 2) & 1) == 0) begin
		return spriteColor;
	end else if (lit) begin
		return palette[col];
	end
	return bgColor;
endfunction

`endif

/* verif/visualizerTb.sv */
`timescale 1ns/100ps

module visualizerTb
	import audioPkg::*;
	import screenPkg::*;
();

	localparam int ackTimeout = 16;
	localparam int drainTimeout = 400;

	logic clk;
	logic rst;
	logic sampleValid;
	logic signed [sampleWidth-1:0] sample;
	wbReqT wbIn;
	wbRspT wbOut;
	logic pixValid;
	pixelT pix;
	logic rgbValid;
	rgbT rgb;
	logic audValid;
	logic signed [sampleWidth-1:0] audOut;

	int errCount;
	int testCount;
	int cycleCount;
	logic signed [sampleWidth-1:0] expAud [$];
	rgbT expRgb [$];
	int expStamp [$];
	logic signed [sampleWidth-1:0] audHead;
	rgbT rgbHead;
	int stampHead;

	`include "visualizerModel.svh"

	visualizerTop visualizerTop_inst (
		.clk(clk), .rst(rst), .sampleValid(sampleValid), .sample(sample),
		.wbIn(wbIn), .wbOut(wbOut), .pixValid(pixValid), .pix(pix),
		.rgbValid(rgbValid), .rgb(rgb), .audValid(audValid), .audOut(audOut)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	// mixed audio checked against the model in sample order
	always @(negedge clk) begin
		if (audValid) begin
			assert (expAud.size() > 0) else begin
				errCount++;
				$display("audValid pulsed with no sample outstanding");
			end
			if (expAud.size() > 0) begin
				audHead = expAud.pop_front();
				assert (audOut == audHead) else begin
					errCount++;
					$display("ERR audOut expected %h got %h", audHead, audOut);
				end
			end
		end
	end

	// each pixel color is due 3 cycles after its pixel
	always @(negedge clk) begin
		if (rgbValid) begin
			assert (expRgb.size() > 0) else begin
				errCount++;
				$display("rgbValid pulsed with no pixel outstanding");
			end
			if (expRgb.size() > 0) begin
				rgbHead = expRgb.pop_front();
				stampHead = expStamp.pop_front();
				assert (rgb == rgbHead) else begin
					errCount++;
					$display("ERR rgb expected %h got %h", rgbHead, rgb);
				end
				assert (cycleCount == stampHead + 3) else begin
					errCount++;
					$display("rgb arrived %0d cycles after its pixel instead of 3",
						cycleCount - stampHead);
				end
			end
		end
	end

	task automatic abortRun(input string why);
		$display("timeout: %s", why);
		$display("tests failed");
		$finish;
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errCount - errBefore);
		end
	endtask

	// one classic cycle held until ack and then watched for a second ack
	task automatic wbAccess(input logic we, input logic [wbAdrWidth-1:0] adr,
			input logic [wbDataWidth-1:0] wdat, output logic [wbDataWidth-1:0] rdat);
		wbReqT req;
		int n;
		int acks;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.adr = adr;
		req.dat = wdat;
		@(posedge clk);
		wbIn <= req;
		n = 0;
		@(negedge clk);
		while (!wbOut.ack) begin
			if (n == ackTimeout) begin
				abortRun("Wishbone access got no ack");
			end
			n++;
			@(negedge clk);
		end
		acks = 1;
		rdat = wbOut.dat;
		@(posedge clk);
		wbIn <= '0;
		repeat (2) begin
			@(negedge clk);
			if (wbOut.ack) begin
				acks++;
			end
		end
		assert (acks == 1) else begin
			errCount++;
			$display("access to register %0d got %0d acks instead of one", adr, acks);
		end
	endtask

	task automatic writeReg(input logic [wbAdrWidth-1:0] adr, input logic [wbDataWidth-1:0] dat);
		logic [wbDataWidth-1:0] unused;
		wbAccess(1'b1, adr, dat, unused);
		applyWrite(adr, dat);
	endtask

	task automatic checkRead(input logic [wbAdrWidth-1:0] adr);
		logic [wbDataWidth-1:0] rd;
		logic [wbDataWidth-1:0] exp;
		wbAccess(1'b0, adr, '0, rd);
		exp = regValue(adr);
		assert (rd == exp) else begin
			errCount++;
			$display("ERR wbOut.dat reg %0d expected %h got %h", adr, exp, rd);
		end
	endtask

	task automatic sendSample(input logic signed [sampleWidth-1:0] s);
		@(posedge clk);
		sampleValid <= 1'b1;
		sample <= s;
		expAud.push_back(stepAudio(int'(s)));
		@(posedge clk);
		sampleValid <= 1'b0;
		repeat ($urandom % 3) @(posedge clk);
	endtask

	// pixels go back to back with an idle cycle now and then
	task automatic sendPixel(input int x, input int y);
		pixelT p;
		p.x = xWidth'(x);
		p.y = yWidth'(y);
		@(posedge clk);
		pixValid <= 1'b1;
		pix <= p;
		expRgb.push_back(pixelColor(int'(p.x), int'(p.y)));
		expStamp.push_back(cycleCount + 1);
		if ($urandom % 4 == 0) begin
			@(posedge clk);
			pixValid <= 1'b0;
		end
	endtask

	task automatic endPixels();
		@(posedge clk);
		pixValid <= 1'b0;
	endtask

	task automatic waitDrain();
		int n;
		n = 0;
		@(posedge clk);
		while (expAud.size() > 0 || expRgb.size() > 0) begin
			if (n == drainTimeout) begin
				abortRun("expected outputs never appeared");
			end
			n++;
			@(posedge clk);
		end
	endtask

	// levels follow the last envelope update by one cycle
	task automatic settleAudio();
		waitDrain();
		repeat (2) @(posedge clk);
	endtask

	initial begin
		int errBefore;
		int sx;
		int sy;
		int oy;
		real amp;
		real period;
		clk = 1'b0;
		rst = 1'b1;
		sampleValid = 1'b0;
		sample = '0;
		wbIn = '0;
		pixValid = 1'b0;
		pix = '0;
		errCount = 0;
		testCount = 0;
		cycleCount = 0;
		void'($urandom(32'h15d4_a574));
		resetModel();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!audValid && !rgbValid) else begin
			errCount++;
			$display("audValid or rgbValid high right after reset");
		end

		errBefore = errCount;
		for (int a = 0; a < 4; a++) begin
			checkRead(wbAdrWidth'(a));
		end
		repeat (3) begin
			for (int a = 0; a < 4; a++) begin
				writeReg(wbAdrWidth'(a), $urandom);
			end
			for (int a = 0; a < 4; a++) begin
				checkRead(wbAdrWidth'(a));
			end
		end
		writeReg(regBandEn, 32'h7f);
		writeReg(regSprCtrl, 32'h0);
		reportTest("registers", errBefore);

		errBefore = errCount;
		repeat (400) sendSample(sampleWidth'($urandom));
		waitDrain();
		reportTest("audio mix", errBefore);

		// at least one band stays off
		errBefore = errCount;
		writeReg(regBandEn, $urandom % 127);
		repeat (300) sendSample(sampleWidth'($urandom));
		settleAudio();
		for (int c = 0; c < numBands; c++) begin
			for (int r = 0; r < gridRows; r++) begin
				sendPixel(gridX0 + c * colPitch + colWidth / 2,
					gridY0 + r * rowPitch + rowHeight / 2);
			end
		end
		endPixels();
		waitDrain();
		reportTest("band gating", errBefore);

		errBefore = errCount;
		writeReg(regBandEn, 32'h7f);
		repeat (4) begin
			period = 2.0 + real'($urandom % 60);
			amp = 1000.0 + real'($urandom % 30000);
			for (int n = 0; n < 96; n++) begin
				sendSample(sampleWidth'($rtoi(amp * $sin(6.2831853 * n / period))));
			end
		end
		settleAudio();
		repeat (300) sendPixel($urandom % 640, $urandom % 480);
		endPixels();
		waitDrain();
		reportTest("bars", errBefore);

		errBefore = errCount;
		// alternating full swings keep band 0 loud so the sprite bobs
		for (int n = 0; n < 64; n++) begin
			sendSample((n % 2 == 0) ? 16'sd12000 : -16'sd12000);
		end
		settleAudio();
		sx = 16 + $urandom % 580;
		sy = 40 + $urandom % 400;
		writeReg(regSprX, sx);
		writeReg(regSprY, sy);
		writeReg(regSprCtrl, 32'h1);
		oy = spriteOriginY();
		repeat (400) sendPixel(sx - 8 + $urandom % 48, oy - 8 + $urandom % 48);
		endPixels();
		waitDrain();
		reportTest("sprite", errBefore);

		waitDrain();
		$display("summary: %0d tests run, %0d errors", testCount, errCount);
		if (errCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+verif
common/audioPkg.sv
common/screenPkg.sv
audio/bandFilterBank.sv
audio/bandMeter.sv
src/ctrlRegs.sv
screen/tileLocate.sv
screen/layerEval.sv
screen/compositor.sv
src/visualizerTop.sv
verif/visualizerTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = visualizerTb
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: compile run clean

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
